/* dcache_subsystem.f */
design/mem_pkg.sv
design/cache_pkg.sv
design/dcache_store.sv
design/dcache_ctrl.sv
design/data_memory.sv
design/dcache_subsystem.sv
testbench/dcache_subsystem_assertions.sv
testbench/dcache_subsystem_tb.sv

/* Bender.yml */
package:
  name: dcache_subsystem

sources:
  # packages first, cache_pkg uses mem_pkg
  - files:
      - design/mem_pkg.sv
      - design/cache_pkg.sv
      - design/dcache_store.sv
      - design/dcache_ctrl.sv
      - design/data_memory.sv
      - design/dcache_subsystem.sv

  - target: simulation
    files:
      - testbench/dcache_subsystem_assertions.sv
      - testbench/dcache_subsystem_tb.sv

/* testbench/dcache_subsystem_tb.sv */
`timescale 1ns/1ps

module dcache_subsystem_tb;
    import mem_pkg::*;
    import cache_pkg::*;

    localparam int clk_half     = 2;
    localparam int drive_delay  = 1;
    localparam int done_timeout = 20;
    localparam int window_words = 64;
    localparam int num_random   = 400;
    // latencies from the first sampling edge in idle
    localparam int hit_cycles   = 2;
    localparam int miss_cycles  = 7;
    localparam int write_cycles = 2 + mem_write_cycles;

    logic                  clk;
    logic                  reset_n;
    cpu_req_t              req;
    logic                  done;
    logic [word_width-1:0] rdata;
    logic [15:0]           hit_count;
    logic [15:0]           miss_count;

    // reference model of memory window and cache tags
    logic [word_width-1:0] model_mem   [window_words];
    logic                  model_valid [num_lines];
    logic [tag_width-1:0]  model_tag   [num_lines];
    int                    exp_hits;
    int                    exp_misses;
    int                    seed;

    dcache_subsystem i_dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .req        (req),
        .done       (done),
        .rdata      (rdata),
        .hit_count  (hit_count),
        .miss_count (miss_count)
    );

    always begin
        #(clk_half) clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns: no done within %0d cycles of a %s", $time,
                 done_timeout, what);
        $display("Simulation FAILED");
        $fatal(1, "stopped on timeout");
    endtask

    // counts edges from the one that samples the request
    task automatic wait_for_done(input string what, output int cycles);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && (n < done_timeout)) begin
            @(posedge clk);
            #(drive_delay);
            n++;
            if (done === 1'b1) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            report_timeout(what);
        end
        cycles = n;
    endtask

    task automatic do_read(input logic [word_width-1:0] addr);
        cache_addr_t           a;
        logic                  was_hit;
        logic [word_width-1:0] exp_data;
        int                    exp_cycles;
        int                    cycles;
        a        = cache_addr_t'(addr);
        exp_data = model_mem[int'(addr)];
        was_hit  = model_valid[a.index] && (model_tag[a.index] == a.tag);
        if (was_hit) begin
            exp_hits++;
            exp_cycles = hit_cycles;
        end else begin
            // a miss refills the whole line
            exp_misses++;
            exp_cycles            = miss_cycles;
            model_valid[a.index] = 1'b1;
            model_tag[a.index]   = a.tag;
        end
        @(posedge clk);
        #(drive_delay);
        req = '{read: 1'b1, write: 1'b0, addr: addr, wdata: '0};
        wait_for_done("read", cycles);
        req = '0;
        assert (cycles == exp_cycles) else
            report_error($sformatf("read of %h took %0d cycles, expected %0d",
                                   addr, cycles, exp_cycles));
        assert (rdata == exp_data) else
            report_error($sformatf("read of %h returned %h, expected %h",
                                   addr, rdata, exp_data));
        assert ((hit_count == exp_hits) && (miss_count == exp_misses)) else
            report_error($sformatf("counters hit %0d miss %0d, expected %0d and %0d",
                                   hit_count, miss_count, exp_hits, exp_misses));
    endtask

    task automatic do_write(input logic [word_width-1:0] addr,
                            input logic [word_width-1:0] wdata);
        int cycles;
        // write-through, tags untouched on hit or miss
        model_mem[int'(addr)] = wdata;
        @(posedge clk);
        #(drive_delay);
        req = '{read: 1'b0, write: 1'b1, addr: addr, wdata: wdata};
        wait_for_done("write", cycles);
        req = '0;
        assert (cycles == write_cycles) else
            report_error($sformatf("write to %h took %0d cycles, expected %0d",
                                   addr, cycles, write_cycles));
        assert ((hit_count == exp_hits) && (miss_count == exp_misses)) else
            report_error($sformatf("write to %h changed the read counters", addr));
    endtask

    initial begin
        logic [15:0]           hits_before;
        logic [15:0]           misses_before;
        logic [word_width-1:0] addr;
        logic [word_width-1:0] wdata;
        int                    op;
        seed        = 40;
        exp_hits    = 0;
        exp_misses  = 0;
        clk         = 1'b0;
        reset_n     = 1'b1;
        req         = '0;
        for (int i = 0; i < window_words; i++) begin
            model_mem[i] = '0;
        end
        for (int i = 0; i < num_lines; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end
        repeat (2) @(posedge clk);
        #(drive_delay);
        reset_n = 1'b0;

        // first read after reset misses and sees zero
        do_read(16'h0005);
        assert ((miss_count == 16'd1) && (hit_count == 16'd0) && (rdata == '0)) else
            report_error("first read after reset did not miss with zero data");

        // write hit then read back from the cache
        do_write(16'h0005, 16'hbeef);
        hits_before = hit_count;
        do_read(16'h0005);
        assert ((hit_count == hits_before + 16'd1) && (rdata == 16'hbeef)) else
            report_error("read after write hit did not hit with the new word");

        // write miss to an aliasing address leaves the line alone
        do_write(16'h0015, 16'h1234);
        misses_before = miss_count;
        do_read(16'h0015);
        assert ((miss_count == misses_before + 16'd1) && (rdata == 16'h1234)) else
            report_error("read after write miss did not refill the written word");
        do_read(16'h0005);

        // random mix inside a small window so lines alias
        for (int i = 0; i < num_random; i++) begin
            op    = $random(seed);
            addr  = 16'($random(seed)) & 16'(window_words - 1);
            wdata = 16'($random(seed));
            if (op[0]) begin
                do_write(addr, wdata);
            end else begin
                do_read(addr);
            end
        end

        @(posedge clk);
        #(drive_delay);
        assert (i_dut.u_ctrl.i_assertions.violation_count == 0) else
            report_error("bound controller assertions reported a violation");
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* testbench/dcache_subsystem_assertions.sv */
`timescale 1ns/1ps

module dcache_subsystem_assertions (
    input logic                           clk,
    input logic                           reset_n,
    input logic                           done,
    input mem_pkg::mem_req_t              mem_req,
    input logic [mem_pkg::word_width-1:0] req_addr
);
    import mem_pkg::*;
    import cache_pkg::*;

    // read back by the testbench at the end of the run
    int violation_count = 0;

    // done is a single-cycle pulse
    done_single_cycle: assert property (
        @(posedge clk) disable iff (reset_n)
        done |=> !done
    ) else begin
        $error("done stayed high for more than one cycle");
        violation_count++;
    end

    strobes_exclusive: assert property (
        @(posedge clk) disable iff (reset_n)
        !(mem_req.read && mem_req.write)
    ) else begin
        $error("memory read and write strobes high together");
        violation_count++;
    end

    // block base is the latched address with the offset bits dropped
    refill_in_block: assert property (
        @(posedge clk) disable iff (reset_n)
        mem_req.read |->
            (mem_req.addr[word_width-1:offset_width] == req_addr[word_width-1:offset_width])
    ) else begin
        $error("refill read address left the requested block");
        violation_count++;
    end

    quiet_after_reset: assert property (
        @(posedge clk)
        reset_n |=> (!done && !mem_req.read && !mem_req.write)
    ) else begin
        $error("done or a memory strobe high right after reset");
        violation_count++;
    end

endmodule

bind dcache_ctrl dcache_subsystem_assertions i_assertions (
    .clk      (clk),
    .reset_n  (reset_n),
    .done     (done),
    .mem_req  (mem_req),
    .req_addr (req_q.addr)
);

/* design/dcache_subsystem.sv */
`timescale 1ns/1ps

module dcache_subsystem (
    input  logic                           clk,
    input  logic                           reset_n,
    input  mem_pkg::cpu_req_t              req,
    output logic                           done,
    output logic [mem_pkg::word_width-1:0] rdata,
    output logic [15:0]                    hit_count,
    output logic [15:0]                    miss_count
);
    import mem_pkg::*;
    import cache_pkg::*;

    // controller to store
    logic [index_width-1:0]  rd_index;
    logic                    wr_en;
    logic [index_width-1:0]  wr_index;
    logic [offset_width-1:0] wr_offset;
    logic [word_width-1:0]   wr_word;
    logic                    tag_en;
    logic [index_width-1:0]  tag_index;
    logic [tag_width-1:0]    tag;
    cache_line_t             rd_line;

    // controller to memory
    mem_req_t              mem_req;
    logic [word_width-1:0] mem_rdata;

    dcache_ctrl u_ctrl (
        .clk        (clk),
        .reset_n    (reset_n),
        .req        (req),
        .done       (done),
        .rdata      (rdata),
        .rd_index   (rd_index),
        .wr_en      (wr_en),
        .wr_index   (wr_index),
        .wr_offset  (wr_offset),
        .wr_word    (wr_word),
        .tag_en     (tag_en),
        .tag_index  (tag_index),
        .tag        (tag),
        .rd_line    (rd_line),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata),
        .hit_count  (hit_count),
        .miss_count (miss_count)
    );

    dcache_store u_store (
        .clk       (clk),
        .reset_n   (reset_n),
        .rd_index  (rd_index),
        .rd_line   (rd_line),
        .wr_en     (wr_en),
        .wr_index  (wr_index),
        .wr_offset (wr_offset),
        .wr_word   (wr_word),
        .tag_en    (tag_en),
        .tag_index (tag_index),
        .tag       (tag)
    );

    data_memory u_mem (
        .clk       (clk),
        .reset_n   (reset_n),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata)
    );

endmodule

/* design/data_memory.sv */
`timescale 1ns/1ps

module data_memory (
    input  logic                           clk,
    input  logic                           reset_n,
    input  mem_pkg::mem_req_t              mem_req,
    output logic [mem_pkg::word_width-1:0] mem_rdata
);
    import mem_pkg::*;

    logic [word_width-1:0] mem_q [mem_depth];

    // whole array cleared at reset
    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < mem_depth; i++) begin
                mem_q[i] <= '0;
            end
        end else if (mem_req.write) begin
            mem_q[mem_req.addr] <= mem_req.wdata;
        end
    end

    // registered read, word shows one cycle after the strobe
    always_ff @(posedge clk) begin
        if (mem_req.read) begin
            mem_rdata <= mem_q[mem_req.addr];
        end else begin
            mem_rdata <= '0;
        end
    end

endmodule

/* design/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                               clk,
    input  logic                               reset_n,
    // processor side
    input  mem_pkg::cpu_req_t                  req,
    output logic                               done,
    output logic [mem_pkg::word_width-1:0]     rdata,
    // store side
    output logic [cache_pkg::index_width-1:0]  rd_index,
    output logic                               wr_en,
    output logic [cache_pkg::index_width-1:0]  wr_index,
    output logic [cache_pkg::offset_width-1:0] wr_offset,
    output logic [mem_pkg::word_width-1:0]     wr_word,
    output logic                               tag_en,
    output logic [cache_pkg::index_width-1:0]  tag_index,
    output logic [cache_pkg::tag_width-1:0]    tag,
    input  cache_pkg::cache_line_t             rd_line,
    // memory side
    output mem_pkg::mem_req_t                  mem_req,
    input  logic [mem_pkg::word_width-1:0]     mem_rdata,
    // read statistics
    output logic [15:0]                        hit_count,
    output logic [15:0]                        miss_count
);
    import mem_pkg::*;
    import cache_pkg::*;

    ctrl_state_t             state;
    cpu_req_t                req_q;
    cache_addr_t             addr_q;
    logic                    hit;
    logic                    word_in;
    logic [offset_width:0]   issue_cnt;
    logic [offset_width-1:0] recv_cnt;
    logic [2:0]              wait_cnt;

    assign addr_q = cache_addr_t'(req_q.addr);

    // tag compare on the indexed line
    assign hit = rd_line.valid && (rd_line.tag == addr_q.tag);

    // a refill word is on mem_rdata one cycle after its strobe was sampled
    assign word_in = ((state == st_refill) && (issue_cnt > 1)) ||
                     (state == st_refill_last);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state      <= st_idle;
            mem_req    <= '0;
            issue_cnt  <= '0;
            recv_cnt   <= '0;
            wait_cnt   <= '0;
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            // strobes last one cycle, bus idles at zero
            mem_req <= '0;
            case (state)
                st_idle: begin
                    if (req.read || req.write) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    if (req_q.write) begin
                        // write-through, hit or miss
                        mem_req.write <= 1'b1;
                        mem_req.addr  <= req_q.addr;
                        mem_req.wdata <= req_q.wdata;
                        wait_cnt      <= 3'(mem_write_cycles - 1);
                        state         <= st_write_wait;
                    end else if (hit) begin
                        hit_count <= hit_count + 16'd1;
                        state     <= st_done;
                    end else begin
                        miss_count   <= miss_count + 16'd1;
                        // first strobe of the block, aligned to word 0
                        mem_req.read <= 1'b1;
                        mem_req.addr <= {addr_q.tag, addr_q.index, {offset_width{1'b0}}};
                        issue_cnt    <= 1;
                        recv_cnt     <= '0;
                        state        <= st_refill;
                    end
                end
                st_refill: begin
                    if (issue_cnt < words_per_line) begin
                        mem_req.read <= 1'b1;
                        mem_req.addr <= {addr_q.tag, addr_q.index,
                                         issue_cnt[offset_width-1:0]};
                        issue_cnt    <= issue_cnt + 1'b1;
                    end
                    if (word_in) begin
                        recv_cnt <= recv_cnt + 1'b1;
                        // next word to land is the last one
                        if (recv_cnt == offset_width'(words_per_line - 2)) begin
                            state <= st_refill_last;
                        end
                    end
                end
                st_refill_last: begin
                    state <= st_done;
                end
                st_write_wait: begin
                    if (wait_cnt == 3'd0) begin
                        state <= st_done;
                    end else begin
                        wait_cnt <= wait_cnt - 3'd1;
                    end
                end
                st_done: begin
                    // request still high here is not taken again
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle) begin
            req_q <= req;
        end
        if ((state == st_lookup) && req_q.read && hit) begin
            rdata <= rd_line.data[addr_q.offset];
        end
        // earlier words already sit in the store, the last one is still on the bus
        if (state == st_refill_last) begin
            if (addr_q.offset == recv_cnt) begin
                rdata <= mem_rdata;
            end else begin
                rdata <= rd_line.data[addr_q.offset];
            end
        end
    end

    // store port: refill words take priority, else a write hit
    assign rd_index  = addr_q.index;
    assign wr_index  = addr_q.index;
    assign tag_index = addr_q.index;
    assign tag       = addr_q.tag;
    assign wr_en     = word_in || ((state == st_lookup) && req_q.write && hit);
    assign wr_offset = word_in ? recv_cnt : addr_q.offset;
    assign wr_word   = word_in ? mem_rdata : req_q.wdata;
    // tag and valid go in with the last word
    assign tag_en    = (state == st_refill_last);

    assign done = (state == st_done);

endmodule

/* design/dcache_store.sv */
`timescale 1ns/1ps

module dcache_store (
    input  logic                               clk,
    input  logic                               reset_n,
    // lookup port
    input  logic [cache_pkg::index_width-1:0]  rd_index,
    output cache_pkg::cache_line_t             rd_line,
    // word write port
    input  logic                               wr_en,
    input  logic [cache_pkg::index_width-1:0]  wr_index,
    input  logic [cache_pkg::offset_width-1:0] wr_offset,
    input  logic [mem_pkg::word_width-1:0]     wr_word,
    // tag update, also sets valid
    input  logic                               tag_en,
    input  logic [cache_pkg::index_width-1:0]  tag_index,
    input  logic [cache_pkg::tag_width-1:0]    tag
);
    import cache_pkg::*;

    logic                 valid_q [num_lines];
    logic [tag_width-1:0] tag_q   [num_lines];
    line_data_t           data_q  [num_lines];

    // only valid bits are cleared
    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < num_lines; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (tag_en) begin
            valid_q[tag_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_en) begin
            tag_q[tag_index] <= tag;
        end
    end

    // one word of one line per cycle
    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_q[wr_index][wr_offset] <= wr_word;
        end
    end

    // combinational read so lookup completes in a single cycle
    assign rd_line = '{
        valid: valid_q[rd_index],
        tag:   tag_q[rd_index],
        data:  data_q[rd_index]
    };

endmodule

/* design/cache_pkg.sv */
package cache_pkg;

    // direct-mapped geometry, 4 lines of 4 words
    localparam int num_lines      = 4;
    localparam int words_per_line = 4;

    // address split of a 16-bit word address
    localparam int tag_width    = 12;
    localparam int index_width  = 2;
    localparam int offset_width = 2;

    // tag | index | offset
    typedef struct packed {
        logic [tag_width-1:0]    tag;
        logic [index_width-1:0]  index;
        logic [offset_width-1:0] offset;
    } cache_addr_t;

    // one block of words, word 0 in the low bits
    typedef logic [words_per_line-1:0][mem_pkg::word_width-1:0] line_data_t;

    // 1 + 12 + 64 = 77 bits
    typedef struct packed {
        logic                 valid;
        logic [tag_width-1:0] tag;
        line_data_t           data;
    } cache_line_t;

    // controller states
    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_refill,
        st_refill_last,
        st_write_wait,
        st_done
    } ctrl_state_t;

endpackage

/* design/mem_pkg.sv */
package mem_pkg;

    // address and data are both one 16-bit word
    localparam int word_width = 16;

    // full word-addressed space
    localparam int mem_depth = 65536;

    // cycles a memory write keeps the controller busy after the strobe
    localparam int mem_write_cycles = 4;

    // request from the processor, levels held until done
    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [word_width-1:0] addr;
        logic [word_width-1:0] wdata;
    } cpu_req_t;

    // bus toward data memory, one-cycle strobes
    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [word_width-1:0] addr;
        logic [word_width-1:0] wdata;
    } mem_req_t;

endpackage
